//--- Bender.yml
package:
  name: fetch_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/fetch_pkg.sv
      - design/fetch_pc_mux.sv
      - design/fetch_bus_ctrl.sv
      - design/fetch_fifo.sv
      - design/fetch_id_reg.sv
      - design/fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/fetch_mem_model.sv
      - bench/tb_fetch_top.sv

//--- bench/fetch_mem_model.sv
/*
  Instruction memory responder for the fetch bus, in-order responses only.
  Only the handshake lives here, data and error bits are derived from resp_addr_o.
*/
module fetch_mem_model (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [31:0]      rnd_i,
  input  logic             instr_req_i,
  input  fetch_pkg::addr_t instr_addr_i,
  output logic             instr_gnt_o,
  output logic             instr_rvalid_o,
  output fetch_pkg::addr_t resp_addr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // granted requests waiting for their response slot
  fetch_pkg::addr_t addr_q[$];
  int unsigned      due_q[$];
  int unsigned      cyc;
  logic             gnt_en_q;

  // grant is random, about three cycles out of four
  assign instr_gnt_o = instr_req_i && gnt_en_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q.delete();
      due_q.delete();
      cyc = 0;
      gnt_en_q       <= 1'b0;
      instr_rvalid_o <= 1'b0;
      resp_addr_o    <= '0;
    end else begin
      cyc = cyc + 1;
      gnt_en_q <= (rnd_i[31:30] != 2'b00);
      // response delay of 0 to 3 extra cycles after the grant
      if (instr_req_i && gnt_en_q) begin
        addr_q.push_back(instr_addr_i);
        due_q.push_back(cyc + rnd_i[29:28]);
      end
      // head only, so order is kept even with shorter later delays
      if ((addr_q.size() != 0) && (due_q[0] <= cyc)) begin
        instr_rvalid_o <= 1'b1;
        resp_addr_o    <= addr_q[0];
        addr_q.delete(0);
        due_q.delete(0);
      end else begin
        instr_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_fetch_top.sv
/*
  Testbench for fetch_top with a randomized instruction memory.
  Every delivered word is checked against a model pc, word and error bit.
  Stops at the first mismatch; a watchdog bounds the run.
*/
`include "fetch_macros.svh"

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 1ps;

  // word counts per phase add up to this
  localparam int unsigned total_words     = 107;
  localparam int unsigned watchdog_cycles = 40 * total_words;
  // bus error window of four words
  localparam fetch_pkg::addr_t err_lo = 32'h0000_2000;
  localparam fetch_pkg::addr_t err_hi = 32'h0000_2010;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  fetch_pkg::addr_t       boot_addr_i;
  logic                   req_i;
  logic                   instr_req_o;
  fetch_pkg::addr_t       instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  fetch_pkg::instr_t      instr_rdata_i;
  logic                   instr_err_i;
  logic                   pc_set_i;
  fetch_pkg::pc_sel_e     pc_mux_i;
  fetch_pkg::exc_pc_sel_e exc_pc_mux_i;
  logic                   exc_irq_int_i;
  fetch_pkg::irq_vec_t    exc_irq_vec_i;
  fetch_pkg::addr_t       branch_target_ex_i;
  fetch_pkg::addr_t       csr_mepc_i;
  fetch_pkg::addr_t       csr_depc_i;
  fetch_pkg::addr_t       csr_mtvec_i;
  logic                   csr_mtvec_init_o;
  logic                   pmp_err_if_i;
  logic                   id_in_ready_i;
  logic                   instr_valid_clear_i;
  logic                   instr_valid_id_o;
  logic                   instr_new_id_o;
  fetch_pkg::instr_t      instr_rdata_id_o;
  logic                   instr_fetch_err_o;
  fetch_pkg::addr_t       pc_id_o;
  fetch_pkg::addr_t       pc_if_o;
  logic                   if_busy_o;

  fetch_pkg::addr_t resp_addr;
  logic [31:0]      rnd = 32'h81db2170;
  logic [4:0]       gap_cnt = '0;
  logic             bp_en;
  logic             pmp_en;
  int unsigned      words_seen = 0;
  // compare process state
  fetch_pkg::addr_t model_pc;
  logic             pmp_prev = 1'b0;

  //////////////////////
  // reference model
  //////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every address bit feeds the word
  function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t a);
    return (a * 32'h0100_0193) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic in_err_window(input fetch_pkg::addr_t a);
    return (a >= err_lo) && (a < err_hi);
  endfunction

  function automatic fetch_pkg::addr_t exp_redirect_pc(
    input fetch_pkg::pc_sel_e     sel,
    input fetch_pkg::exc_pc_sel_e exc_sel,
    input logic                   irq_int,
    input fetch_pkg::irq_vec_t    vec
  );
    fetch_pkg::addr_t    trap_base;
    fetch_pkg::addr_t    boot_pc;
    fetch_pkg::addr_t    exc_pc;
    fetch_pkg::irq_vec_t cause;
    trap_base = csr_mtvec_i & 32'hFFFF_FF00;
    boot_pc   = (boot_addr_i & 32'hFFFF_FF00) | 32'(`FETCH_BOOT_OFFSET);
    cause     = irq_int ? `FETCH_NMI_VEC : vec;
    case (exc_sel)
      fetch_pkg::EXC_PC_IRQ:     exc_pc = trap_base + 32'(cause) * 4;
      fetch_pkg::EXC_PC_DBD:     exc_pc = `FETCH_DM_HALT_ADDR;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = `FETCH_DM_EXC_ADDR;
      default:                   exc_pc = trap_base;
    endcase
    case (sel)
      fetch_pkg::PC_JUMP: return branch_target_ex_i;
      fetch_pkg::PC_EXC:  return exc_pc;
      fetch_pkg::PC_ERET: return csr_mepc_i;
      fetch_pkg::PC_DRET: return csr_depc_i;
      default:            return boot_pc;
    endcase
  endfunction

  //////////////////////
  // checks
  //////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_t got,
                             input fetch_pkg::instr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  //////////////////////
  // DUT and memory
  //////////////////////

  fetch_top dut0 (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .boot_addr_i        (boot_addr_i),
    .req_i              (req_i),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_err_i        (instr_err_i),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_irq_int_i      (exc_irq_int_i),
    .exc_irq_vec_i      (exc_irq_vec_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .csr_mtvec_init_o   (csr_mtvec_init_o),
    .pmp_err_if_i       (pmp_err_if_i),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o),
    .pc_if_o            (pc_if_o),
    .if_busy_o          (if_busy_o)
  );

  fetch_mem_model mem0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rnd_i         (rnd),
    .instr_req_i   (instr_req_o),
    .instr_addr_i  (instr_addr_o),
    .instr_gnt_o   (instr_gnt_i),
    .instr_rvalid_o(instr_rvalid_i),
    .resp_addr_o   (resp_addr)
  );

  // response payload straight from the reference
  assign instr_rdata_i = mem_word(resp_addr);
  assign instr_err_i   = in_err_window(resp_addr);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    rnd <= lcg_next(rnd);
  end

  // decode readiness with occasional long gaps and a clear that follows ready
  always @(posedge clk_i) begin
    if (gap_cnt != '0) begin
      id_in_ready_i       <= 1'b0;
      instr_valid_clear_i <= 1'b0;
      gap_cnt             <= gap_cnt - 1'b1;
    end else if (bp_en && (rnd[23:21] == 3'd0)) begin
      id_in_ready_i       <= 1'b0;
      instr_valid_clear_i <= 1'b0;
      gap_cnt             <= 5'd1 + rnd[27:24];
    end else begin
      id_in_ready_i       <= 1'b1;
      instr_valid_clear_i <= 1'b1;
    end
    pmp_err_if_i <= pmp_en && rnd[19];
  end

  // compare process
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_bit("csr_mtvec_init_o", csr_mtvec_init_o,
                pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT));
      // the word belongs to the current stream and a redirect only affects later words
      if (instr_new_id_o) begin
        check_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
        check_addr("pc_id_o", pc_id_o, model_pc);
        check_instr("instr_rdata_id_o", instr_rdata_id_o, mem_word(model_pc));
        check_bit("instr_fetch_err_o", instr_fetch_err_o,
                  in_err_window(model_pc) || pmp_prev);
        model_pc = model_pc + 32'd4;
        // fifo head moved one word past the accepted one
        check_addr("pc_if_o", pc_if_o, model_pc);
        words_seen <= words_seen + 1;
      end
      if (pc_set_i) begin
        model_pc = exp_redirect_pc(pc_mux_i, exc_pc_mux_i, exc_irq_int_i, exc_irq_vec_i);
      end
      // pmp level seen at the accepting edge
      pmp_prev = pmp_err_if_i;
    end
  end

  //////////////////////
  // stimulus
  //////////////////////

  // one-cycle pc_set_i pulse issued at a rising edge
  task automatic redirect(input fetch_pkg::pc_sel_e sel, input fetch_pkg::exc_pc_sel_e exc_sel,
                          input logic irq_int, input fetch_pkg::irq_vec_t vec);
    pc_set_i      <= 1'b1;
    pc_mux_i      <= sel;
    exc_pc_mux_i  <= exc_sel;
    exc_irq_int_i <= irq_int;
    exc_irq_vec_i <= vec;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  task automatic jump_to(input fetch_pkg::addr_t target);
    branch_target_ex_i <= target;
    redirect(fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0);
  endtask

  task automatic wait_words(input int unsigned n);
    int unsigned target;
    target = words_seen + n;
    while (words_seen < target) begin
      @(posedge clk_i);
    end
  endtask

  task automatic wait_idle(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (if_busy_o && (n < max_cycles)) begin
      @(posedge clk_i);
      n++;
    end
    if (if_busy_o) begin
      abort_run("if_busy_o stayed high although no new requests were allowed");
    end
  endtask

  initial begin
    rst_ni             = 1'b0;
    req_i              = 1'b0;
    boot_addr_i        = 32'h0000_0100;
    pc_set_i           = 1'b0;
    pc_mux_i           = fetch_pkg::PC_BOOT;
    exc_pc_mux_i       = fetch_pkg::EXC_PC_EXC;
    exc_irq_int_i      = 1'b0;
    exc_irq_vec_i      = '0;
    branch_target_ex_i = '0;
    csr_mepc_i         = 32'h0000_3000;
    csr_depc_i         = 32'h0000_4000;
    csr_mtvec_i        = 32'h0000_5000;
    pmp_err_if_i       = 1'b0;
    id_in_ready_i      = 1'b1;
    instr_valid_clear_i = 1'b1;
    bp_en              = 1'b0;
    pmp_en             = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
    check_bit("instr_new_id_o", instr_new_id_o, 1'b0);
    check_bit("if_busy_o", if_busy_o, 1'b0);
    // req_i rises with the boot redirect so no request has an unknown address
    req_i <= 1'b1;
    redirect(fetch_pkg::PC_BOOT, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0);
    wait_words(6);
    jump_to(32'h0000_1000);
    wait_words(5);
    redirect(fetch_pkg::PC_ERET, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0);
    wait_words(4);
    redirect(fetch_pkg::PC_DRET, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0);
    wait_words(4);
    // every exception entry where an internal irq overrides the given cause
    redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0);
    wait_words(4);
    redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ, 1'b0, 5'd5);
    wait_words(4);
    redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ, 1'b1, 5'd5);
    wait_words(4);
    redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBD, 1'b0, 5'd0);
    wait_words(4);
    redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBG_EXC, 1'b0, 5'd0);
    wait_words(4);
    // run across the bus error window
    jump_to(32'h0000_1FF8);
    wait_words(8);
    // long stream under random back-pressure
    bp_en <= 1'b1;
    jump_to(32'h0000_6000);
    wait_words(40);
    bp_en  <= 1'b0;
    pmp_en <= 1'b1;
    jump_to(32'h0000_7000);
    wait_words(16);
    pmp_en <= 1'b0;
    // stop fetching and let the bus drain
    req_i <= 1'b0;
    @(posedge clk_i);
    wait_idle(100);
    repeat (20) begin
      @(posedge clk_i);
      check_bit("instr_req_o", instr_req_o, 1'b0);
    end
    req_i <= 1'b1;
    jump_to(32'h0000_8000);
    wait_words(4);
    $display("Result: PASSED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    abort_run($sformatf("timeout, only %0d of %0d words delivered", words_seen, total_words));
  end

endmodule

//--- design/fetch_bus_ctrl.sv
/*
  Word fetch controller for a req/gnt/rvalid bus with in-order responses.
  A pending request keeps its address until granted, even across a redirect.
  fifo_count_i must be the registered occupancy of the prefetch FIFO.
*/
`include "fetch_macros.svh"

module fetch_bus_ctrl (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_i,
  input  logic                                     branch_i,
  input  fetch_pkg::addr_t                         branch_addr_i,
  input  logic [$clog2(`FETCH_FIFO_DEPTH + 1)-1:0] fifo_count_i,
  output logic                                     instr_req_o,
  output fetch_pkg::addr_t                         instr_addr_o,
  input  logic                                     instr_gnt_i,
  input  logic                                     instr_rvalid_i,
  input  fetch_pkg::instr_t                        instr_rdata_i,
  input  logic                                     instr_err_i,
  output logic                                     push_o,
  output fetch_pkg::instr_t                        push_rdata_o,
  output logic                                     push_err_o,
  output logic                                     busy_o
);

  localparam int unsigned CntW = $clog2(`FETCH_FIFO_DEPTH + 1);

  typedef enum logic {
    IDLE,
    WAIT_GNT
  } state_e;

  state_e           state_q, state_d;
  fetch_pkg::addr_t req_addr_q;
  fetch_pkg::addr_t next_addr_q, next_addr_d;
  fetch_pkg::addr_t issue_addr;
  logic             stale_q, stale_d;
  logic [CntW-1:0]  os_q, os_d;
  logic [CntW-1:0]  disc_q, disc_d;
  logic [CntW-1:0]  fifo_used;
  logic [CntW:0]    fill;
  logic             space;
  logic             issue;
  logic             gnt_any;
  logic             gnt_stale;
  logic             drop;

  // fifo is flushed on a branch, so its old words no longer take space
  assign fifo_used = branch_i ? '0 : fifo_count_i;
  // every outstanding response owns a fifo slot, discards included
  assign fill      = {1'b0, os_q} + {1'b0, fifo_used};
  assign space     = (fill < `FETCH_FIFO_DEPTH) && (os_q < `FETCH_MAX_OUTSTANDING);

  assign issue      = (state_q == IDLE) && req_i && space;
  assign issue_addr = branch_i ? branch_addr_i : next_addr_q;

  // bus side
  assign instr_req_o  = (state_q == WAIT_GNT) || issue;
  assign instr_addr_o = (state_q == WAIT_GNT) ? req_addr_q : issue_addr;

  assign gnt_any   = instr_req_o && instr_gnt_i;
  // a pending request from before a redirect returns a word nobody wants
  assign gnt_stale = instr_gnt_i && (state_q == WAIT_GNT) && (stale_q || branch_i);

  // responses of the old stream are thrown away
  assign drop         = instr_rvalid_i && (branch_i || (disc_q != '0));
  assign push_o       = instr_rvalid_i && !drop;
  assign push_rdata_o = instr_rdata_i;
  assign push_err_o   = instr_err_i;

  assign busy_o = (state_q == WAIT_GNT) || (os_q != '0);

  ////////////////////
  // request fsm
  ////////////////////

  always_comb begin
    state_d     = state_q;
    stale_d     = stale_q;
    next_addr_d = next_addr_q;
    if (state_q == IDLE) begin
      if (issue) begin
        next_addr_d = issue_addr + fetch_pkg::addr_t'(4);
        if (!instr_gnt_i) begin
          state_d = WAIT_GNT;
          stale_d = 1'b0;
        end
      end else if (branch_i) begin
        next_addr_d = branch_addr_i;
      end
    end else begin
      // redirect while waiting only moves the follow-up address
      if (branch_i) begin
        next_addr_d = branch_addr_i;
      end
      stale_d = stale_q || branch_i;
      if (instr_gnt_i) begin
        state_d = IDLE;
        stale_d = 1'b0;
      end
    end
  end

  // outstanding and discard bookkeeping
  always_comb begin
    os_d = os_q;
    if (gnt_any) begin
      os_d = os_d + 1'b1;
    end
    if (instr_rvalid_i) begin
      os_d = os_d - 1'b1;
    end
    // on a branch all in-flight responses turn into discards
    disc_d = branch_i ? os_q : disc_q;
    if (drop) begin
      disc_d = disc_d - 1'b1;
    end
    if (gnt_stale) begin
      disc_d = disc_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      stale_q <= 1'b0;
      os_q    <= '0;
      disc_q  <= '0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
      os_q    <= os_d;
      disc_q  <= disc_d;
    end
  end

  // addresses
  always_ff @(posedge clk_i) begin
    next_addr_q <= next_addr_d;
    if (issue && !instr_gnt_i) begin
      req_addr_q <= issue_addr;
    end
  end

endmodule

//--- design/fetch_fifo.sv
/*
  Prefetch FIFO of fetched words, kept in arrival order.
  Push into a full FIFO is not checked, the writer must track free space.
*/
module fetch_fifo #(
  parameter int unsigned Depth = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  fetch_pkg::addr_t             flush_addr_i,
  input  logic                         push_i,
  input  fetch_pkg::instr_t            push_rdata_i,
  input  logic                         push_err_i,
  input  logic                         ready_i,
  output logic                         valid_o,
  output fetch_pkg::instr_t            rdata_o,
  output fetch_pkg::addr_t             addr_o,
  output logic                         err_o,
  output logic [$clog2(Depth + 1)-1:0] count_o
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  fetch_pkg::instr_t rdata_q [Depth];
  logic [Depth-1:0]  err_q;
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   count_q;
  fetch_pkg::addr_t  addr_q;
  logic              wr_en;
  logic              pop;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // flush wins over a push or pop in the same cycle
  assign wr_en = push_i && !flush_i;
  assign pop   = valid_o && ready_i && !flush_i;

  assign valid_o = (count_q != '0);
  assign rdata_o = rdata_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign addr_o  = addr_q;
  assign count_o = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leave the count alone
      if (wr_en && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      rdata_q[wr_ptr_q] <= push_rdata_i;
      err_q[wr_ptr_q]   <= push_err_i;
    end
  end

  // head address, follows the sequential stream after each redirect
  always_ff @(posedge clk_i) begin
    if (flush_i) begin
      addr_q <= flush_addr_i;
    end else if (pop) begin
      addr_q <= addr_q + fetch_pkg::addr_t'(4);
    end
  end

endmodule

//--- design/fetch_id_reg.sv
/*
  IF-ID pipeline register, frozen while decode is not ready.
  A word popped in the same cycle as pc_set_i is squashed.
*/
module fetch_id_reg (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fetch_valid_i,
  input  fetch_pkg::instr_t fetch_rdata_i,
  input  fetch_pkg::addr_t  fetch_addr_i,
  input  logic              fetch_err_i,
  input  logic              pmp_err_if_i,
  input  logic              pc_set_i,
  input  logic              id_in_ready_i,
  input  logic              instr_valid_clear_i,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output fetch_pkg::instr_t instr_rdata_id_o,
  output logic              instr_fetch_err_o,
  output fetch_pkg::addr_t  pc_id_o,
  output fetch_pkg::addr_t  pc_if_o
);

  logic accept;
  logic valid_d, valid_q;
  logic new_q;

  // handshake with the fifo head, a redirect kills the word in flight
  assign accept = fetch_valid_i && id_in_ready_i && !pc_set_i;

  // valid holds until decode clears it
  assign valid_d = accept || (valid_q && !instr_valid_clear_i);

  ////////////////////
  // flags
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // single cycle marker for each captured word
      new_q   <= accept;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      pc_id_o           <= fetch_addr_i;
      // bus and pmp faults both end up as a fetch error
      instr_fetch_err_o <= fetch_err_i || pmp_err_if_i;
    end
  end

  // pc of the word waiting at the fifo head
  assign pc_if_o = fetch_addr_i;

endmodule

//--- design/fetch_pc_mux.sv
/*
  Purely combinational next-pc selection.
  An unknown pc_mux_i value falls back to the boot address.
*/
`include "fetch_macros.svh"

module fetch_pc_mux (
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                   exc_irq_int_i,
  input  fetch_pkg::irq_vec_t    exc_irq_vec_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_ex_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output fetch_pkg::addr_t       fetch_addr_o,
  output logic                   csr_mtvec_init_o
);

  fetch_pkg::irq_vec_t irq_vec;
  fetch_pkg::addr_t    exc_pc;
  fetch_pkg::addr_t    boot_pc;

  // internal interrupts are funneled onto a single vector
  assign irq_vec = exc_irq_int_i ? `FETCH_NMI_VEC : exc_irq_vec_i;

  assign boot_pc = {boot_addr_i[31:8], `FETCH_BOOT_OFFSET};

  ////////////////////
  // exception target
  ////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      // vectored mode, each cause gets one word
      fetch_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
      fetch_pkg::EXC_PC_DBD:     exc_pc = `FETCH_DM_HALT_ADDR;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = `FETCH_DM_EXC_ADDR;
      default:                   exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  ////////////////////
  // redirect target
  ////////////////////

  always_comb begin
    case (pc_mux_i)
      fetch_pkg::PC_BOOT: fetch_addr_o = boot_pc;
      fetch_pkg::PC_JUMP: fetch_addr_o = branch_target_ex_i;
      fetch_pkg::PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap handler
      fetch_pkg::PC_ERET: fetch_addr_o = csr_mepc_i;
      // return from debug mode
      fetch_pkg::PC_DRET: fetch_addr_o = csr_depc_i;
      default:            fetch_addr_o = boot_pc;
    endcase
  end

  // mtvec is loaded from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

//--- design/fetch_pkg.sv
/*
  Types shared by the fetch RTL and its testbench.
  Encodings of pc_sel_e and exc_pc_sel_e are fixed and must match the controller.
*/
`include "fetch_macros.svh"

package fetch_pkg;

  // fetch address and instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [`FETCH_XLEN-1:0] instr_t;

  // interrupt cause index, selects one of 32 vectors
  typedef logic [4:0] irq_vec_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of exception entry
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

//--- design/fetch_top.sv
/*
  Instruction fetch stage, word-aligned 32-bit instructions only.
  boot_addr_i and csr_mtvec_i are assumed 256-byte aligned.
  The bus must return responses in order.
*/
`include "fetch_macros.svh"

module fetch_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  logic                   instr_err_i,
  // redirect control
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                   exc_irq_int_i,
  input  fetch_pkg::irq_vec_t    exc_irq_vec_i,
  input  fetch_pkg::addr_t       branch_target_ex_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output logic                   csr_mtvec_init_o,
  // towards the decode stage
  input  logic                   pmp_err_if_i,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   instr_fetch_err_o,
  output fetch_pkg::addr_t       pc_id_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   if_busy_o
);

  // redirect address, valid only together with pc_set_i
  fetch_pkg::addr_t fetch_addr_n;

  // controller to fifo
  logic                                    push;
  fetch_pkg::instr_t                       push_rdata;
  logic                                    push_err;
  logic [$clog2(`FETCH_FIFO_DEPTH + 1)-1:0] fifo_count;

  // fifo head towards the IF-ID register
  logic              fetch_valid;
  logic              fetch_ready;
  fetch_pkg::instr_t fetch_rdata;
  fetch_pkg::addr_t  fetch_addr;
  logic              fetch_err;

  // no skid stage, decode ready goes straight to the fifo
  assign fetch_ready = id_in_ready_i;

  fetch_pc_mux u_pc_mux (
    .pc_set_i          (pc_set_i),
    .pc_mux_i          (pc_mux_i),
    .exc_pc_mux_i      (exc_pc_mux_i),
    .exc_irq_int_i     (exc_irq_int_i),
    .exc_irq_vec_i     (exc_irq_vec_i),
    .boot_addr_i       (boot_addr_i),
    .branch_target_ex_i(branch_target_ex_i),
    .csr_mepc_i        (csr_mepc_i),
    .csr_depc_i        (csr_depc_i),
    .csr_mtvec_i       (csr_mtvec_i),
    .fetch_addr_o      (fetch_addr_n),
    .csr_mtvec_init_o  (csr_mtvec_init_o)
  );

  // pc_set_i is the branch strobe for the controller
  fetch_bus_ctrl u_bus_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (fetch_addr_n),
    .fifo_count_i  (fifo_count),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .push_o        (push),
    .push_rdata_o  (push_rdata),
    .push_err_o    (push_err),
    .busy_o        (if_busy_o)
  );

  // ... and the flush for the fifo
  fetch_fifo #(
    .Depth(`FETCH_FIFO_DEPTH)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (pc_set_i),
    .flush_addr_i(fetch_addr_n),
    .push_i      (push),
    .push_rdata_i(push_rdata),
    .push_err_i  (push_err),
    .ready_i     (fetch_ready),
    .valid_o     (fetch_valid),
    .rdata_o     (fetch_rdata),
    .addr_o      (fetch_addr),
    .err_o       (fetch_err),
    .count_o     (fifo_count)
  );

  fetch_id_reg u_id_reg (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid),
    .fetch_rdata_i      (fetch_rdata),
    .fetch_addr_i       (fetch_addr),
    .fetch_err_i        (fetch_err),
    .pmp_err_if_i       (pmp_err_if_i),
    .pc_set_i           (pc_set_i),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o),
    .pc_if_o            (pc_if_o)
  );

endmodule

//--- fetch_top.f
+incdir+include
design/fetch_pkg.sv
design/fetch_pc_mux.sv
design/fetch_bus_ctrl.sv
design/fetch_fifo.sv
design/fetch_id_reg.sv
design/fetch_top.sv
bench/fetch_mem_model.sv
bench/tb_fetch_top.sv

//--- include/fetch_macros.svh
/*
  Fixed sizes and addresses of the fetch stage.
  FETCH_MAX_OUTSTANDING must not exceed FETCH_FIFO_DEPTH.
*/
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// data path width, addresses and instruction words
`define FETCH_XLEN 32

// prefetch storage and bus pipelining
`define FETCH_FIFO_DEPTH 3
`define FETCH_MAX_OUTSTANDING 2

// low byte of the boot pc, upper bits come from boot_addr_i
`define FETCH_BOOT_OFFSET 8'h80

// debug module entry points
`define FETCH_DM_HALT_ADDR 32'h1A110800
`define FETCH_DM_EXC_ADDR 32'h1A110808

// all internal interrupts share this vector
`define FETCH_NMI_VEC 5'd31

`endif
